// File: readDataChannel.f
logic/readChannelPkg.sv
logic/readBeatIf.sv
logic/readArbiter.sv
logic/readSlaveSide.sv
logic/readMasterSide.sv
logic/readDataChannel.sv
tests/readDataChannel_properties.sv
tests/readDataChannelTb.sv

// File: Bender.yml
package:
  name: readDataChannel

sources:
  - logic/readChannelPkg.sv
  - logic/readBeatIf.sv
  - logic/readArbiter.sv
  - logic/readSlaveSide.sv
  - logic/readMasterSide.sv
  - logic/readDataChannel.sv
  - target: test
    files:
      - tests/readDataChannel_properties.sv
      - tests/readDataChannelTb.sv

// File: tests/readDataChannelTb.sv
// Default widths only, one beat in flight at a time, master back-pressure of up to three cycles
`timescale 1ns/100ps
`default_nettype none

module readDataChannelTb;

    localparam int rowCount  = 7;
    localparam int maxDelay  = 3;
    // Four beats per row at most, each a few cycles plus the ready delay
    localparam int timeLimit = (rowCount * 4 * (maxDelay + 8) + 20) * 40;

    // Data holds one 16-bit tag per slave, delay 4'hf draws a random delay
    typedef struct packed {
        logic [3:0]  mask;
        logic [3:0]  idTop;
        logic [15:0] idLow;
        logic [3:0]  last;
        logic [7:0]  resp;
        logic [63:0] data;
        logic [3:0]  delay;
    } stimRow;

    stimRow                        stimTable [rowCount];
    logic                          clock;
    logic                          resetn;
    readChannelPkg::slaveGrant     slaveValid;
    readChannelPkg::slaveGrant     slaveLast;
    logic [3:0][63:0]              slaveData;
    logic [3:0][4:0]               slaveId;
    readChannelPkg::readResp [3:0] slaveResp;
    readChannelPkg::slaveGrant     slaveReady;
    logic [1:0]                    masterReady;
    logic [1:0]                    masterValid;
    logic [1:0]                    masterLast;
    logic [1:0][63:0]              masterData;
    logic [1:0][3:0]               masterId;
    readChannelPkg::readResp [1:0] masterResp;
    int                            errorCount;
    int                            checkCount;
    int                            pointer;
    integer                        seed;

    readDataChannel readDataChannel_inst (.*);

    initial clock = 1'b0;
    always #20 clock = ~clock;

    task automatic checkValue(input string name, input logic [63:0] got,
                              input logic [63:0] expected);
        checkCount++;
        assert (got === expected) else
        begin
            errorCount++;
            $display("error: %s expected %h got %h at %0t", name, expected, got, $time);
        end
    endtask

    // Beat as seen on the master named by the ID top bit
    task automatic checkBeat(input int r, input int k);
        int m;
        m = stimTable[r].idTop[k];
        checkValue("masterValid", masterValid, 2'b01 << m);
        checkValue("masterData", masterData[m], {4{stimTable[r].data[16*k +: 16]}});
        checkValue("masterId", masterId[m], stimTable[r].idLow[4*k +: 4]);
        checkValue("masterLast", masterLast[m], stimTable[r].last[k]);
        checkValue("masterResp", masterResp[m], stimTable[r].resp[2*k +: 2]);
    endtask

    task automatic driveRow(input int r);
        for (int k = 0; k < 4; k++)
        begin
            slaveData[k] = {4{stimTable[r].data[16*k +: 16]}};
            slaveId[k]   = {stimTable[r].idTop[k], stimTable[r].idLow[4*k +: 4]};
            slaveLast[k] = stimTable[r].last[k];
            slaveResp[k] = stimTable[r].resp[2*k +: 2];
        end
        slaveValid = stimTable[r].mask;
    endtask

    // First pending slave at or after the priority pointer
    function automatic int pickWinner(input logic [3:0] pending, input int from);
        int k;
        pickWinner = -1;
        for (int offset = 3; offset >= 0; offset--)
        begin
            k = (from + offset) % 4;
            if (pending[k])
                pickWinner = k;
        end
    endfunction

    //////////////////////////////////////////////////
    // Stimulus and checks
    //////////////////////////////////////////////////
    initial
    begin
        logic [3:0] pending;
        int         winner;
        int         delay;

        seed        = 32'h2102_c391;
        errorCount  = 0;
        checkCount  = 0;
        pointer     = 0;
        resetn      = 1'b0;
        slaveValid  = '0;
        slaveLast   = '0;
        slaveData   = '0;
        slaveId     = '0;
        slaveResp   = '0;
        masterReady = 2'b00;
        //              mask     idTop    idLow     last     resp   data                    delay
        stimTable[0] = {4'b0001, 4'b0000, 16'h0005, 4'b0001, 8'h00, 64'h0000_0000_0000_a1b2, 4'd0};
        stimTable[1] = {4'b0100, 4'b0100, 16'h0a00, 4'b0000, 8'h20, 64'h0000_c3d4_0000_0000, 4'd2};
        stimTable[2] = {4'b1111, 4'b0110, 16'h3c5f, 4'b1010, 8'hb4, 64'h1111_2222_3333_4444, 4'd1};
        stimTable[3] = {4'b1010, 4'b1000, 16'h9060, 4'b1000, 8'h48, 64'hdead_0000_beef_0000, 4'hf};
        stimTable[4] = {4'b0011, 4'b0010, 16'h00e7, 4'b0011, 8'h0e, 64'h0000_0000_5a5a_a5a5, 4'd3};
        stimTable[5] = {4'b1001, 4'b0001, 16'hf00c, 4'b1001, 8'hc3, 64'h7777_0000_0000_8888, 4'd0};
        stimTable[6] = {4'b0110, 4'b0100, 16'h0b70, 4'b0110, 8'h3c, 64'h0000_9999_6666_0000, 4'hf};

        repeat (4) @(posedge clock);
        @(negedge clock);
        resetn = 1'b1;
        checkValue("masterValid", masterValid, 2'b00);
        checkValue("slaveReady", slaveReady, 4'b0000);

        for (int r = 0; r < rowCount; r++)
        begin
            driveRow(r);
            pending = stimTable[r].mask;
            while (pending != 4'b0000)
            begin
                winner = pickWinner(pending, pointer);
                if (stimTable[r].delay == 4'hf)
                    delay = {$random(seed)} % (maxDelay + 1);
                else
                    delay = stimTable[r].delay;
                @(negedge clock);
                // Valid is due one cycle after the slave beat is sampled
                checkCount++;
                assert (masterValid != 2'b00) else
                begin
                    errorCount++;
                    $display("master valid did not rise in the cycle after the slave beat at %0t",
                             $time);
                end
                while (masterValid == 2'b00)
                    @(negedge clock);
                checkBeat(r, winner);
                // Held beat under back-pressure
                repeat (delay)
                begin
                    checkValue("slaveReady", slaveReady, 4'b0000);
                    @(negedge clock);
                    checkBeat(r, winner);
                end
                masterReady[stimTable[r].idTop[winner]] = 1'b1;
                @(negedge clock);
                checkValue("masterValid", masterValid, 2'b00);
                checkValue("slaveReady", slaveReady, 4'b0001 << winner);
                masterReady        = 2'b00;
                slaveValid[winner] = 1'b0;
                @(negedge clock);
                checkValue("slaveReady", slaveReady, 4'b0000);
                // No new grant while the ready pulse was out
                checkValue("masterValid", masterValid, 2'b00);
                pending[winner] = 1'b0;
                pointer         = (winner + 1) % 4;
            end
        end

        $display("checks run %0d, errors %0d", checkCount, errorCount);
        if (errorCount == 0)
            $display("PASS: all tests");
        else
            $display("FAIL: see errors above");
        $finish;
    end

    initial
    begin
        #(timeLimit);
        $display("timeout: expected beat or handshake never completed within %0d ns", timeLimit);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

`default_nettype wire

// File: tests/readDataChannel_properties.sv
// Port-level rules for the default build of two masters and four slaves, bound to the top level
`timescale 1ns/100ps
`default_nettype none

module readDataChannelProperties #(
    parameter int dataWidth = 64
) (
    input logic                      clock,
    input logic                      resetn,
    input readChannelPkg::slaveGrant slaveReady,
    input logic [1:0]                masterReady,
    input logic [1:0]                masterValid,
    input logic [1:0][dataWidth-1:0] masterData
);

    masterExclusive: assert property (@(posedge clock) disable iff (!resetn)
        !(masterValid[0] && masterValid[1]))
        else $error("both master valids high");

    slaveReadyOneHot: assert property (@(posedge clock) disable iff (!resetn)
        $onehot0(slaveReady))
        else $error("more than one slave ready high");

    // Back-pressure holds the beat
    masterHold0: assert property (@(posedge clock) disable iff (!resetn)
        masterValid[0] && !masterReady[0] |=> masterValid[0] && $stable(masterData[0]))
        else $error("master 0 beat dropped or changed under back-pressure");

    masterHold1: assert property (@(posedge clock) disable iff (!resetn)
        masterValid[1] && !masterReady[1] |=> masterValid[1] && $stable(masterData[1]))
        else $error("master 1 beat dropped or changed under back-pressure");

    readyAfterHandshake: assert property (@(posedge clock) disable iff (!resetn)
        |slaveReady |-> $past(|(masterValid & masterReady)))
        else $error("slave ready without a master handshake one cycle earlier");

endmodule

bind readDataChannel readDataChannelProperties #(.dataWidth(dataWidth))
    readDataChannelProperties_inst (.*);

`default_nettype wire

// File: logic/readDataChannel.sv
// Four slaves to two masters with one beat in flight and slave ID one bit wider than master ID
`timescale 1ns/100ps
`default_nettype none

module readDataChannel #(
    parameter int dataWidth = 64,
    parameter int idWidth   = 4
) (
    input  logic                                                clock,
    input  logic                                                resetn,

    // Slave ports, indexed by slave
    input  readChannelPkg::slaveGrant                           slaveValid,
    input  readChannelPkg::slaveGrant                           slaveLast,
    input  logic [readChannelPkg::slaveCount-1:0][dataWidth-1:0] slaveData,
    input  logic [readChannelPkg::slaveCount-1:0][idWidth:0]     slaveId,
    input  readChannelPkg::readResp [readChannelPkg::slaveCount-1:0] slaveResp,
    output readChannelPkg::slaveGrant                           slaveReady,

    // Master ports, indexed by master
    input  logic [1:0]                                          masterReady,
    output logic [1:0]                                          masterValid,
    output logic [1:0]                                          masterLast,
    output logic [1:0][dataWidth-1:0]                           masterData,
    output logic [1:0][idWidth-1:0]                             masterId,
    output readChannelPkg::readResp [1:0]                       masterResp
);

    readChannelPkg::slaveGrant grant;
    logic                      beatAccepted;
    logic                      sharedLast;
    logic [dataWidth-1:0]      sharedData;
    logic [idWidth-1:0]        sharedId;
    readChannelPkg::readResp   sharedResp;

    readBeatIf #(.dataWidth(dataWidth), .idWidth(idWidth)) beat ();

    readArbiter readArbiter_inst (
        .clock        (clock),
        .resetn       (resetn),
        .slaveValid   (slaveValid),
        .slaveReady   (slaveReady),
        .beatAccepted (beatAccepted),
        .grant        (grant)
    );

    readSlaveSide #(.dataWidth(dataWidth), .idWidth(idWidth)) readSlaveSide_inst (
        .clock        (clock),
        .resetn       (resetn),
        .grant        (grant),
        .beatAccepted (beatAccepted),
        .slaveValid   (slaveValid),
        .slaveLast    (slaveLast),
        .slaveData    (slaveData),
        .slaveId      (slaveId),
        .slaveResp    (slaveResp),
        .beat         (beat.source),
        .slaveReady   (slaveReady)
    );

    readMasterSide #(.dataWidth(dataWidth), .idWidth(idWidth)) readMasterSide_inst (
        .clock        (clock),
        .resetn       (resetn),
        .grant        (grant),
        .beat         (beat.sink),
        .masterReady  (masterReady),
        .masterValid  (masterValid),
        .masterLast   (sharedLast),
        .masterData   (sharedData),
        .masterId     (sharedId),
        .masterResp   (sharedResp),
        .beatAccepted (beatAccepted)
    );

    // Both masters see the same held beat fields
    assign masterLast = {2{sharedLast}};
    assign masterData = {2{sharedData}};
    assign masterId   = {2{sharedId}};
    assign masterResp = {2{sharedResp}};

endmodule

`default_nettype wire

// File: logic/readMasterSide.sv
// Only two masters, picked by the top ID bit, and data, last, id and resp are shared by both
`timescale 1ns/100ps
`default_nettype none

module readMasterSide #(
    parameter int dataWidth = 64,
    parameter int idWidth   = 4
) (
    input  logic                      clock,
    input  logic                      resetn,
    input  readChannelPkg::slaveGrant grant,
    readBeatIf.sink                   beat,
    input  logic [1:0]                masterReady,
    output logic [1:0]                masterValid,
    output logic                      masterLast,
    output logic [dataWidth-1:0]      masterData,
    output logic [idWidth-1:0]        masterId,
    output readChannelPkg::readResp   masterResp,
    output logic                      beatAccepted
);

    logic captureBeat;
    // Master that holds the current beat
    logic routeSelect;

    assign captureBeat = (|grant) && beat.valid;

    // Handshake on the routed master only
    assign beatAccepted = masterValid[routeSelect] && masterReady[routeSelect];

    //////////////////////////////////////////////////
    // Valid routing
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            masterValid <= 2'b00;
            routeSelect <= 1'b0;
        end
        else if (captureBeat)
        begin
            routeSelect <= beat.id[idWidth];
            masterValid <= beat.id[idWidth] ? 2'b10 : 2'b01;
        end
        else if (beatAccepted)
        begin
            masterValid <= 2'b00;
        end
    end

    //////////////////////////////////////////////////
    // Beat output register
    //////////////////////////////////////////////////
    always_ff @(posedge clock)
    begin
        if (captureBeat)
        begin
            masterLast <= beat.last;
            masterData <= beat.data;
            // Select bit is dropped towards the master
            masterId   <= beat.id[idWidth-1:0];
            masterResp <= beat.resp;
        end
        else if (beatAccepted)
        begin
            masterLast <= 1'b0;
            masterData <= '0;
            masterId   <= '0;
            masterResp <= '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/readSlaveSide.sv
// Fields are zero when nothing is granted and a slave must hold its beat until its ready pulse
`timescale 1ns/100ps
`default_nettype none

module readSlaveSide #(
    parameter int dataWidth = 64,
    parameter int idWidth   = 4
) (
    input  logic                                                clock,
    input  logic                                                resetn,
    input  readChannelPkg::slaveGrant                           grant,
    input  logic                                                beatAccepted,
    input  readChannelPkg::slaveGrant                           slaveValid,
    input  readChannelPkg::slaveGrant                           slaveLast,
    input  logic [readChannelPkg::slaveCount-1:0][dataWidth-1:0] slaveData,
    input  logic [readChannelPkg::slaveCount-1:0][idWidth:0]     slaveId,
    input  readChannelPkg::readResp [readChannelPkg::slaveCount-1:0] slaveResp,
    readBeatIf.source                                           beat,
    output readChannelPkg::slaveGrant                           slaveReady
);

    // Slave whose beat is in flight
    readChannelPkg::slaveGrant winner;

    //////////////////////////////////////////////////
    // Beat multiplexer
    //////////////////////////////////////////////////
    always_comb
    begin
        beat.valid = 1'b0;
        beat.last  = 1'b0;
        beat.data  = '0;
        beat.id    = '0;
        beat.resp  = '0;
        for (int k = 0; k < readChannelPkg::slaveCount; k++)
        begin
            if (grant[k])
            begin
                beat.valid = slaveValid[k];
                beat.last  = slaveLast[k];
                beat.data  = slaveData[k];
                beat.id    = slaveId[k];
                beat.resp  = slaveResp[k];
            end
        end
    end

    //////////////////////////////////////////////////
    // Winner register and ready pulse
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            winner     <= '0;
            slaveReady <= '0;
        end
        else
        begin
            if (|grant)
            begin
                winner <= grant;
            end
            else if (beatAccepted)
            begin
                winner <= '0;
            end

            // One cycle wide, only towards the slave that won
            slaveReady <= beatAccepted ? winner : '0;
        end
    end

endmodule

`default_nettype wire

// File: logic/readArbiter.sv
// Four slaves only, and no new grant is issued while a slave ready pulse is out
`timescale 1ns/100ps
`default_nettype none

module readArbiter (
    input  logic                      clock,
    input  logic                      resetn,
    input  readChannelPkg::slaveGrant slaveValid,
    input  readChannelPkg::slaveGrant slaveReady,
    input  logic                      beatAccepted,
    output readChannelPkg::slaveGrant grant
);

    readChannelPkg::arbState   state;
    readChannelPkg::arbState   nextState;
    readChannelPkg::slaveGrant eligible;

    // A slave in its ready pulse still shows valid, so nothing is
    // granted until the pulse has gone
    assign eligible = (|slaveReady) ? '0 : slaveValid;

    //////////////////////////////////////////////////
    // State register
    //////////////////////////////////////////////////
    always_ff @(posedge clock or negedge resetn)
    begin
        if (!resetn)
        begin
            state <= readChannelPkg::priIdle0;
        end
        else
        begin
            state <= nextState;
        end
    end

    //////////////////////////////////////////////////
    // Grant and next state
    //////////////////////////////////////////////////
    always_comb
    begin
        logic [2:0]                stateCode;
        readChannelPkg::slaveIndex holder;
        readChannelPkg::slaveIndex nextHolder;
        readChannelPkg::slaveIndex candidate;
        logic                      found;

        stateCode  = state;
        holder     = stateCode[1:0];
        nextHolder = holder + 2'd1;
        candidate  = holder;
        found      = 1'b0;
        grant      = '0;
        nextState  = state;

        if (!stateCode[2])
        begin
            // Search from the priority holder, wrapping past slave 3
            for (int offset = 0; offset < readChannelPkg::slaveCount; offset++)
            begin
                candidate = holder + readChannelPkg::slaveIndex'(offset);
                if (!found && eligible[candidate])
                begin
                    found            = 1'b1;
                    grant[candidate] = 1'b1;
                    nextState        = readChannelPkg::arbState'({1'b1, candidate});
                end
            end
        end
        else if (beatAccepted)
        begin
            // Priority moves to the slave after the winner
            nextState = readChannelPkg::arbState'({1'b0, nextHolder});
        end
    end

endmodule

`default_nettype wire

// File: logic/readBeatIf.sv
// Carries the single granted beat and keeps the master select bit at the top of id
`timescale 1ns/100ps
`default_nettype none

interface readBeatIf #(
    parameter int dataWidth = 64,
    parameter int idWidth   = 4
);

    logic                    valid;
    logic                    last;
    logic [dataWidth-1:0]    data;
    // Full slave-side ID including the master select bit
    logic [idWidth:0]        id;
    readChannelPkg::readResp resp;

    modport source (output valid, output last, output data, output id, output resp);

    modport sink (input valid, input last, input data, input id, input resp);

endinterface

`default_nettype wire

// File: logic/readChannelPkg.sv
// Slave count is fixed at four because the arbiter rotates a 2-bit slave index
`default_nettype none

package readChannelPkg;

    // Number of slave ports
    localparam int slaveCount = 4;

    // Read response code carried with each beat
    typedef logic [1:0] readResp;

    // One bit per slave, one-hot while granted
    typedef logic [slaveCount-1:0] slaveGrant;

    // Names one slave
    typedef logic [1:0] slaveIndex;

    // Low two bits name the slave, top bit marks a beat in flight
    typedef enum logic [2:0] {
        priIdle0    = 3'd0,
        priIdle1    = 3'd1,
        priIdle2    = 3'd2,
        priIdle3    = 3'd3,
        waitAccept0 = 3'd4,
        waitAccept1 = 3'd5,
        waitAccept2 = 3'd6,
        waitAccept3 = 3'd7
    } arbState;

endpackage

`default_nettype wire
